// File: hw/cpuDefsPkg.sv
//==========================================================
// core types for the 6502 subset. Status keeps N V Z C only
// and there is no decimal mode.
//==========================================================
package cpuDefsPkg;

  // aaa-bbb-cc split used by the 6502 group decode
  typedef struct packed {
    logic [2:0] aaa;
    logic [2:0] bbb;
    logic [1:0] cc;
  } opcodeFields;

  typedef union packed {
    logic [7:0]  raw;
    opcodeFields field;
  } opcodeWord;

  typedef enum logic [3:0] {
    aluOr, aluAnd, aluEor, aluAdd, aluSub,
    aluCmp, aluInc, aluDec, aluPass
  } aluOp;

  typedef enum logic [1:0] {regA, regX, regY, regNone} regSel;

  typedef enum logic [2:0] {
    modeImplied, modeImmediate, modeZeroPage, modeAbsolute, modeRelative
  } addrMode;

  typedef enum logic [2:0] {
    kindAlu, kindLoad, kindStore, kindTransfer,
    kindFlagOp, kindJump, kindBranch, kindNop
  } instrKind;

  // flag tested by a conditional branch
  typedef enum logic {flagZ, flagC} branchSel;

  typedef struct packed {
    instrKind kind;
    addrMode  mode;
    aluOp     op;
    regSel    srcReg;
    regSel    dstReg;
    logic     setCarry;
    branchSel branchFlag;
    logic     branchWhen;
  } decodedInstr;

  typedef struct packed {
    logic n;
    logic v;
    logic z;
    logic c;
  } statusFlags;

  typedef struct packed {
    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] y;
    statusFlags flags;
  } regView;

  typedef struct packed {
    logic [7:0] value;
    logic       carry;
    logic       overflow;
  } aluResult;

  // regNone reads as zero
  function automatic logic [7:0] selectReg(regView regs, regSel sel);
    case (sel)
      regA:    return regs.a;
      regX:    return regs.x;
      regY:    return regs.y;
      default: return 8'h00;
    endcase
  endfunction

endpackage

// File: hw/busPkg.sv
//==========================================================
// one request per cycle to an asynchronous memory
//==========================================================
package busPkg;

  // read when write is low, data is expected in the same cycle
  typedef struct packed {
    logic [15:0] address;
    logic [7:0]  writeData;
    logic        write;
  } memRequest;

endpackage

// File: hw/instrDecode.sv
//==========================================================
// combinational opcode decode. Opcodes outside the subset
// decode to a one-byte NOP.
//==========================================================
module instrDecode (
  input  cpuDefsPkg::opcodeWord   opcode,
  output cpuDefsPkg::decodedInstr decoded
);
  import cpuDefsPkg::*;

  // group one addressing modes in bbb
  localparam logic [2:0] bbbZeroPage  = 3'b001;
  localparam logic [2:0] bbbImmediate = 3'b010;

  aluOp groupOp;

  function automatic decodedInstr makeInstr(instrKind kind, addrMode mode, aluOp op,
                                            regSel src, regSel dst);
    decodedInstr d;
    d.kind       = kind;
    d.mode       = mode;
    d.op         = op;
    d.srcReg     = src;
    d.dstReg     = dst;
    d.setCarry   = 1'b0;
    d.branchFlag = flagZ;
    d.branchWhen = 1'b0;
    return d;
  endfunction

  function automatic decodedInstr makeBranch(branchSel flag, logic when);
    decodedInstr d;
    d            = makeInstr(kindBranch, modeRelative, aluPass, regNone, regNone);
    d.branchFlag = flag;
    d.branchWhen = when;
    return d;
  endfunction

  always_comb begin
    decoded = makeInstr(kindNop, modeImplied, aluPass, regNone, regNone);
    groupOp = aluPass;

    if (opcode.field.cc == 2'b01) begin
      // aaa picks the operation
      case (opcode.field.aaa)
        3'b000:  groupOp = aluOr;
        3'b001:  groupOp = aluAnd;
        3'b010:  groupOp = aluEor;
        3'b011:  groupOp = aluAdd;
        3'b110:  groupOp = aluCmp;
        3'b111:  groupOp = aluSub;
        default: groupOp = aluPass;
      endcase

      if (opcode.field.bbb == bbbImmediate) begin
        case (opcode.field.aaa)
          // no STA immediate
          3'b100:  ;
          3'b101:  decoded = makeInstr(kindLoad, modeImmediate, aluPass, regNone, regA);
          3'b110:  decoded = makeInstr(kindAlu, modeImmediate, aluCmp, regA, regNone);
          default: decoded = makeInstr(kindAlu, modeImmediate, groupOp, regA, regA);
        endcase
      end else if (opcode.field.bbb == bbbZeroPage) begin
        // only STA and LDA keep zero page
        if (opcode.field.aaa == 3'b100) begin
          decoded = makeInstr(kindStore, modeZeroPage, aluPass, regA, regNone);
        end else if (opcode.field.aaa == 3'b101) begin
          decoded = makeInstr(kindLoad, modeZeroPage, aluPass, regNone, regA);
        end
      end
    end else begin
      case (opcode.raw)
        8'hA2: decoded = makeInstr(kindLoad, modeImmediate, aluPass, regNone, regX);
        8'hA0: decoded = makeInstr(kindLoad, modeImmediate, aluPass, regNone, regY);
        8'h86: decoded = makeInstr(kindStore, modeZeroPage, aluPass, regX, regNone);
        8'h84: decoded = makeInstr(kindStore, modeZeroPage, aluPass, regY, regNone);
        8'hAA: decoded = makeInstr(kindTransfer, modeImplied, aluPass, regA, regX);
        8'hA8: decoded = makeInstr(kindTransfer, modeImplied, aluPass, regA, regY);
        8'h8A: decoded = makeInstr(kindTransfer, modeImplied, aluPass, regX, regA);
        8'h98: decoded = makeInstr(kindTransfer, modeImplied, aluPass, regY, regA);
        8'hE8: decoded = makeInstr(kindAlu, modeImplied, aluInc, regX, regX);
        8'hC8: decoded = makeInstr(kindAlu, modeImplied, aluInc, regY, regY);
        8'hCA: decoded = makeInstr(kindAlu, modeImplied, aluDec, regX, regX);
        8'h88: decoded = makeInstr(kindAlu, modeImplied, aluDec, regY, regY);
        8'h18: decoded = makeInstr(kindFlagOp, modeImplied, aluPass, regNone, regNone);
        8'h38: begin
          decoded          = makeInstr(kindFlagOp, modeImplied, aluPass, regNone, regNone);
          decoded.setCarry = 1'b1;
        end
        8'h4C: decoded = makeInstr(kindJump, modeAbsolute, aluPass, regNone, regNone);
        8'hF0: decoded = makeBranch(flagZ, 1'b1);
        8'hD0: decoded = makeBranch(flagZ, 1'b0);
        8'hB0: decoded = makeBranch(flagC, 1'b1);
        8'h90: decoded = makeBranch(flagC, 1'b0);
        // EA and the rest stay NOP
        default: ;
      endcase
    end
  end

endmodule

// File: hw/aluExecute.sv
//==========================================================
// binary 8-bit ALU. Subtract uses carry as inverted borrow
// and there is no decimal adjust.
//==========================================================
module aluExecute (
  input  cpuDefsPkg::aluOp     op,
  input  logic [7:0]           a,
  input  logic [7:0]           b,
  input  logic                 carryIn,
  output cpuDefsPkg::aluResult result
);
  import cpuDefsPkg::*;

  logic       subtract;
  logic [7:0] addend;
  logic       carryUsed;
  logic [8:0] sum;

  // subtract is a plus not b plus carry
  assign subtract  = (op == aluSub) || (op == aluCmp);
  assign addend    = subtract ? ~b : b;

  // compare never borrows in
  assign carryUsed = (op == aluCmp) ? 1'b1 : carryIn;
  assign sum       = {1'b0, a} + {1'b0, addend} + {8'h00, carryUsed};

  always_comb begin
    result.value = sum[7:0];
    result.carry = sum[8];
    // signed overflow when both inputs agree in sign and the sum does not
    result.overflow = (a[7] == addend[7]) && (sum[7] != a[7]);

    case (op)
      aluOr:   result.value = a | b;
      aluAnd:  result.value = a & b;
      aluEor:  result.value = a ^ b;
      aluInc:  result.value = a + 8'd1;
      aluDec:  result.value = a - 8'd1;
      aluPass: result.value = a;
      // add, subtract and compare take the adder
      default: ;
    endcase
  end

endmodule

// File: hw/resultWriteback.sv
//==========================================================
// A X Y and NVZC. Loads once per commit at the edge that
// ends the commit cycle.
//==========================================================
module resultWriteback (
  input  logic                    phi0,
  input  logic                    reset,
  input  logic                    commit,
  input  cpuDefsPkg::decodedInstr decoded,
  input  cpuDefsPkg::aluResult    alu,
  input  logic [7:0]              operand,
  output cpuDefsPkg::regView      regs
);
  import cpuDefsPkg::*;

  logic [7:0] value;
  logic       writesValue;
  logic       arith;
  regView     nextRegs;

  // loads take the data byte, everything else the ALU
  assign value = (decoded.kind == kindLoad) ? operand : alu.value;

  assign writesValue = (decoded.kind == kindLoad) ||
                       (decoded.kind == kindTransfer) ||
                       (decoded.kind == kindAlu);

  assign arith = (decoded.kind == kindAlu) &&
                 ((decoded.op == aluAdd) || (decoded.op == aluSub) || (decoded.op == aluCmp));

  always_comb begin
    nextRegs = regs;

    if (writesValue) begin
      nextRegs.flags.n = value[7];
      nextRegs.flags.z = (value == 8'h00);
      // CMP has no destination
      case (decoded.dstReg)
        regA:    nextRegs.a = value;
        regX:    nextRegs.x = value;
        regY:    nextRegs.y = value;
        default: ;
      endcase
    end

    if (arith) begin
      nextRegs.flags.c = alu.carry;
      // V only from ADC and SBC
      if (decoded.op != aluCmp) begin
        nextRegs.flags.v = alu.overflow;
      end
    end

    if (decoded.kind == kindFlagOp) begin
      nextRegs.flags.c = decoded.setCarry;
    end
  end

  always_ff @(posedge phi0) begin
    if (reset) begin
      regs <= '0;
    end else if (commit) begin
      regs <= nextRegs;
    end
  end

endmodule

// File: hw/cycleSequencer.sv
//==========================================================
// T-state sequencer. Read data must settle in the cycle of
// its address. RDY stalls read cycles only.
//==========================================================
module cycleSequencer #(
  parameter logic [15:0] RESET_VECTOR = 16'hFFFC
) (
  input  logic                    phi0,
  input  logic                    reset,
  input  logic                    RDY,
  input  logic [7:0]              readData,
  input  cpuDefsPkg::decodedInstr decoded,
  input  cpuDefsPkg::statusFlags  flags,
  input  cpuDefsPkg::regView      regs,
  output busPkg::memRequest       bus,
  output logic                    SYNC,
  output cpuDefsPkg::opcodeWord   opcode,
  output logic [7:0]              operand,
  output logic                    commit
);
  import cpuDefsPkg::*;

  typedef enum logic [2:0] {stVecLo, stVecHi, stFetch, stT1, stT2} tState;

  tState       state;
  logic [15:0] pc;
  // zero page address or branch offset
  logic [7:0]  operandReg;
  // vector or JMP target low byte
  logic [7:0]  addrLow;
  logic        zpAccess;
  logic        branchTaken;
  logic        threeCycle;
  logic        advance;
  logic        lastCycle;

  assign zpAccess = (decoded.kind == kindStore) ||
                    ((decoded.kind == kindLoad) && (decoded.mode == modeZeroPage));

  assign branchTaken = (decoded.kind == kindBranch) &&
                       (((decoded.branchFlag == flagC) ? flags.c : flags.z) ==
                        decoded.branchWhen);

  assign threeCycle = zpAccess || (decoded.kind == kindJump) || branchTaken;

  always_comb begin
    bus.write     = (state == stT2) && (decoded.kind == kindStore);
    bus.writeData = selectReg(regs, decoded.srcReg);
    case (state)
      stVecLo: bus.address = RESET_VECTOR;
      stVecHi: bus.address = RESET_VECTOR + 16'd1;
      stT2:    bus.address = zpAccess ? {8'h00, operandReg} : pc;
      default: bus.address = pc;
    endcase
  end

  // write cycles complete whatever RDY does
  assign advance   = RDY || bus.write;
  assign lastCycle = (state == stT2) || ((state == stT1) && !threeCycle);
  assign commit    = lastCycle && advance;
  assign SYNC      = (state == stFetch);

  // immediate byte or loaded data, both on the bus in the commit cycle
  assign operand = readData;

  always_ff @(posedge phi0) begin
    if (reset) begin
      state <= stVecLo;
    end else if (advance) begin
      case (state)
        stVecLo: begin
          addrLow <= readData;
          state   <= stVecHi;
        end
        stVecHi: begin
          pc    <= {readData, addrLow};
          state <= stFetch;
        end
        stFetch: begin
          opcode.raw <= readData;
          pc         <= pc + 16'd1;
          state      <= stT1;
        end
        stT1: begin
          operandReg <= readData;
          if (decoded.kind == kindJump) begin
            addrLow <= readData;
          end
          // implied ops do a dummy read and keep pc
          if (decoded.mode != modeImplied) begin
            pc <= pc + 16'd1;
          end
          state <= threeCycle ? stT2 : stFetch;
        end
        stT2: begin
          if (decoded.kind == kindJump) begin
            pc <= {readData, addrLow};
          end else if (decoded.kind == kindBranch) begin
            pc <= pc + {{8{operandReg[7]}}, operandReg};
          end
          state <= stFetch;
        end
        default: state <= stFetch;
      endcase
    end
  end

endmodule

// File: hw/core6502.sv
//==========================================================
// 6502 subset core on one rising-edge clock. No interrupts,
// stack or decimal mode.
//==========================================================
module core6502 #(
  parameter logic [15:0] RESET_VECTOR = 16'hFFFC
) (
  input  logic               phi0,
  input  logic               reset,
  input  logic               RDY,
  input  logic [7:0]         readData,
  output busPkg::memRequest  bus,
  output logic               SYNC,
  output cpuDefsPkg::regView regs
);
  import cpuDefsPkg::*;

  opcodeWord   opcode;
  decodedInstr decoded;
  aluResult    aluOut;
  logic [7:0]  operand;
  logic [7:0]  aluA;
  logic        commit;

  // execute stage reads the source register
  assign aluA = selectReg(regs, decoded.srcReg);

  cycleSequencer #(
    .RESET_VECTOR(RESET_VECTOR)
  ) sequencer (
    .phi0     (phi0),
    .reset    (reset),
    .RDY      (RDY),
    .readData (readData),
    .decoded  (decoded),
    .flags    (regs.flags),
    .regs     (regs),
    .bus      (bus),
    .SYNC     (SYNC),
    .opcode   (opcode),
    .operand  (operand),
    .commit   (commit)
  );

  instrDecode decoder (
    .opcode  (opcode),
    .decoded (decoded)
  );

  aluExecute execute (
    .op      (decoded.op),
    .a       (aluA),
    .b       (operand),
    .carryIn (regs.flags.c),
    .result  (aluOut)
  );

  resultWriteback writeback (
    .phi0    (phi0),
    .reset   (reset),
    .commit  (commit),
    .decoded (decoded),
    .alu     (aluOut),
    .operand (operand),
    .regs    (regs)
  );

endmodule

// File: verif/core6502Tb.sv
//==========================================================
// runs verif/programInput.hex on core6502 with random RDY.
// Start from the project root so the hex path resolves.
//==========================================================
module core6502Tb;
  import cpuDefsPkg::*;
  import busPkg::*;

  localparam int clockPeriod  = 40;
  localparam int programBytes = 98;
  // three cycles per byte at most and twice that for stalls
  localparam int watchdogCycles = (programBytes * 3 + 50) * 2;
  localparam logic [15:0] tableBase = 16'hF000;

  logic       phi0 = 1'b0;
  logic       reset;
  logic       RDY;
  logic [7:0] readData;
  memRequest  bus;
  logic       SYNC;
  regView     regs;

  logic [7:0] mem [0:65535];
  integer     seed;

  int          valueErrors;
  int          otherErrors;
  int          writeCount;
  int          expectedCount;
  logic        firstReadSeen;
  logic        firstSyncSeen;
  logic        fetchDone;
  logic        prevStall;
  logic [15:0] prevAddr;
  logic [15:0] lastFetchAddr;
  logic        loopReached;

  core6502 #(
    .RESET_VECTOR(16'hFFFC)
  ) uut (
    .phi0     (phi0),
    .reset    (reset),
    .RDY      (RDY),
    .readData (readData),
    .bus      (bus),
    .SYNC     (SYNC),
    .regs     (regs)
  );

  always #(clockPeriod / 2) phi0 = ~phi0;

  // asynchronous read with data in the same cycle as the address
  assign readData = mem[bus.address];

  // write data lands at the edge that ends the write cycle
  always @(posedge phi0) begin
    if (bus.write) begin
      mem[bus.address] = bus.writeData;
    end
  end

  // low one cycle in four
  always @(posedge phi0) begin
    RDY <= ($random(seed) & 32'h3) != 32'h0;
  end

  function automatic logic [7:0] tableByte(logic [15:0] offset);
    return mem[tableBase + offset];
  endfunction

  // entries are address low, address high, data
  function automatic memRequest expectedWrite(int index);
    logic [15:0] base;
    memRequest   req;
    base          = 16'(1 + 3 * index);
    req.address   = {tableByte(base + 16'd1), tableByte(base)};
    req.writeData = tableByte(base + 16'd2);
    req.write     = 1'b1;
    return req;
  endfunction

  function automatic regView expectedRegs(int count);
    logic [15:0] base;
    logic [7:0]  flagByte;
    regView      r;
    base     = 16'(1 + 3 * count);
    r.a      = tableByte(base);
    r.x      = tableByte(base + 16'd1);
    r.y      = tableByte(base + 16'd2);
    flagByte = tableByte(base + 16'd3);
    r.flags  = flagByte[3:0];
    return r;
  endfunction

  task automatic checkAddress(string name, logic [15:0] expected, logic [15:0] actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("FAIL %s: expected address %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic checkWrite(string name, memRequest expected, memRequest actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("FAIL %s: expected %h at %h, actual %h at %h (write %b)", name,
               expected.writeData, expected.address, actual.writeData,
               actual.address, actual.write);
    end
  endtask

  task automatic checkRegs(string name, regView expected, regView actual);
    if (actual !== expected) begin
      valueErrors++;
      $display("FAIL %s: expected A %h X %h Y %h NVZC %b, actual A %h X %h Y %h NVZC %b",
               name, expected.a, expected.x, expected.y, expected.flags,
               actual.a, actual.x, actual.y, actual.flags);
    end
  endtask

  // bus monitor samples in the middle of each cycle
  always @(negedge phi0) begin
    if (!reset) begin
      if (!firstReadSeen) begin
        checkAddress("first read after reset", 16'hFFFC, bus.address);
        firstReadSeen = 1'b1;
      end
      if (prevStall) begin
        checkAddress("address held while RDY low", prevAddr, bus.address);
      end
      if (SYNC && !firstSyncSeen) begin
        checkAddress("first opcode fetch", {mem[16'hFFFD], mem[16'hFFFC]}, bus.address);
        firstSyncSeen = 1'b1;
      end
      if (bus.write) begin
        if (writeCount < expectedCount) begin
          checkWrite($sformatf("write %0d", writeCount), expectedWrite(writeCount), bus);
        end else begin
          otherErrors++;
          $display("unexpected write of %h to %h after all %0d expected writes",
                   bus.writeData, bus.address, expectedCount);
        end
        writeCount++;
      end
      // two completed fetches in a row at one address mean a jump to itself
      if (SYNC && RDY) begin
        if (fetchDone && (bus.address == lastFetchAddr)) begin
          loopReached = 1'b1;
        end
        lastFetchAddr = bus.address;
        fetchDone     = 1'b1;
      end
      prevStall = !RDY && !bus.write;
      prevAddr  = bus.address;
    end
  end

  initial begin
    #(watchdogCycles * clockPeriod);
    $display("watchdog: the program never reached its final loop within %0d cycles",
             watchdogCycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    seed          = 66;
    valueErrors   = 0;
    otherErrors   = 0;
    writeCount    = 0;
    firstReadSeen = 1'b0;
    firstSyncSeen = 1'b0;
    fetchDone     = 1'b0;
    prevStall     = 1'b0;
    prevAddr      = 16'h0000;
    lastFetchAddr = 16'h0000;
    loopReached   = 1'b0;
    for (int i = 0; i < 65536; i++) begin
      mem[16'(i)] = 8'(i ^ (i >> 8));
    end
    $readmemh("verif/programInput.hex", mem);
    expectedCount = int'(tableByte(16'h0000));

    reset <= 1'b1;
    RDY   <= 1'b1;
    repeat (3) @(posedge phi0);
    reset <= 1'b0;

    wait (loopReached);
    @(negedge phi0);
    checkRegs("final registers", expectedRegs(expectedCount), regs);
    if (writeCount != expectedCount) begin
      otherErrors++;
      $display("the program made %0d writes but the table expects %0d",
               writeCount, expectedCount);
    end

    $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
    if ((valueErrors == 0) && (otherErrors == 0)) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verif/programInput.hex
// one hex byte per word, @ lines set the address
// F000 table: write count, then address low, address high, data per write,
// then final A, X, Y and flags with N V Z C in bits 3 to 0
@0200
A9 05 85 10 A2 80 86 11 A0 00 84 12
F0 02 85 1F
18 A9 7F 69 01 85 13
38 A9 80 E9 01 85 14
B0 02 85 1E
69 80 85 15 C9 00 D0 02 85 16 90 02
A9 3C 29 0F 09 A0 49 FF 85 17
C9 60 90 02 85 1D
AA E8 CA CA 88 C8 C8 86 18 84 19
98 85 1A A5 11 A8 8A EA 84 1B 85 1C
D0 02 85 1E
4C 5E 02 85 1F 38 4C 5F 02
@F000
0D
10 00 05 11 00 80 12 00 00 13 00 80
14 00 7F 15 00 00 16 00 00 17 00 53
18 00 52 19 00 01 1A 00 01 1B 00 80
1C 00 52
52 52 80 01
@FFFC
00 02

// File: vlog.f
hw/cpuDefsPkg.sv
hw/busPkg.sv
hw/instrDecode.sv
hw/aluExecute.sv
hw/resultWriteback.sv
hw/cycleSequencer.sv
hw/core6502.sv
verif/core6502Tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core6502Tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -F -q "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
